// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// first opcode fetched after reset
`define CPU_RESET_PC  16'h0200
`define CPU_RESET_REG 8'h00
`define CPU_RESET_P   8'h00

// one-hot states with initial as all zero, top bit spare
`define CPU_ST_W          6
`define CPU_ST_INITIAL    6'b000000
`define CPU_ST_NEW_OP     6'b000001
`define CPU_ST_LO_BYTE    6'b000010
`define CPU_ST_HI_BYTE    6'b000100
`define CPU_ST_WRITE_DATA 6'b001000
`define CPU_ST_LOAD_REG   6'b010000

// bits in reg_p
`define CPU_P_N 7
`define CPU_P_V 6
`define CPU_P_D 3
`define CPU_P_I 2
`define CPU_P_Z 1
`define CPU_P_C 0

// alu operations
`define CPU_ALU_OP_W 3
`define CPU_ALU_OR   3'd0
`define CPU_ALU_AND  3'd1
`define CPU_ALU_EOR  3'd2
`define CPU_ALU_ADD  3'd3
`define CPU_ALU_SUB  3'd4
`define CPU_ALU_SHL  3'd5
`define CPU_ALU_SHR  3'd6

// register selects
`define CPU_SEL_W 2
`define CPU_SEL_A 2'd0
`define CPU_SEL_X 2'd1
`define CPU_SEL_Y 2'd2

`endif

// File: hw/cpu_pkg.sv
package cpu_pkg;

  // instruction byte seen as 6502 fields or as two nibbles
  typedef struct packed {
    logic [2:0] opcode;
    logic [2:0] amode;
    logic [1:0] group;
  } op_fields_t;

  typedef struct packed {
    logic [3:0] hi;
    logic [3:0] lo;
  } op_nibbles_t;

  typedef union packed {
    op_fields_t  f;
    op_nibbles_t nib;
  } op_word_t;

endpackage

// File: hw/instr_decoder.sv
`include "cpu_settings.svh"

module instr_decoder import cpu_pkg::*; (
  input  op_word_t                   op,
  output logic                       is_load,
  output logic                       is_store,
  output logic                       is_alu,
  output logic                       is_implied,
  output logic                       is_flag_op,
  output logic                       is_jmp,
  output logic                       amode_imm,
  output logic                       amode_zp,
  output logic                       amode_abs,
  output logic                       is_cmp,
  output logic                       is_shift,
  output logic                       is_incdec,
  output logic [`CPU_ALU_OP_W-1:0]   alu_op,
  output logic [`CPU_SEL_W-1:0]      dst_sel,
  output logic [`CPU_SEL_W-1:0]      src_sel
);

  logic                  grp_a;
  logic                  mem_mode;
  logic                  is_trans;
  logic                  is_inc;
  logic [`CPU_SEL_W-1:0] grp_sel;
  logic [`CPU_SEL_W-1:0] xy_sel;

  // immediate sits at amode 010 in group 01 and at 000 elsewhere
  assign grp_a     = op.f.group == 2'b01;
  assign amode_imm = grp_a ? (op.f.amode == 3'b010) : (op.f.amode == 3'b000);
  assign amode_zp  = op.f.amode == 3'b001;
  assign amode_abs = op.f.amode == 3'b011;
  assign mem_mode  = (amode_imm || amode_zp || amode_abs) && op.f.group != 2'b11;

  assign is_load  = op.f.opcode == 3'b101 && mem_mode;
  assign is_store = op.f.opcode == 3'b100 && (amode_zp || amode_abs) && op.f.group != 2'b11;
  assign is_alu   = grp_a && mem_mode && op.f.opcode != 3'b100 && op.f.opcode != 3'b101;
  assign is_cmp   = is_alu && op.f.opcode == 3'b110;
  // accumulator shifts only
  assign is_shift = op.f.group == 2'b10 && op.f.amode == 3'b010 && !op.f.opcode[2];

  // single opcodes from the nibbles
  assign is_trans = (op.nib.lo == 4'hA && (op.nib.hi == 4'h8 || op.nib.hi == 4'hA)) ||
                    (op.nib.lo == 4'h8 && (op.nib.hi == 4'h9 || op.nib.hi == 4'hA));
  assign is_inc    = op.nib.lo == 4'h8 && (op.nib.hi == 4'hE || op.nib.hi == 4'hC);
  assign is_incdec = is_inc || (op.nib.hi == 4'hC && op.nib.lo == 4'hA) ||
                     (op.nib.hi == 4'h8 && op.nib.lo == 4'h8);
  // set/clear flags plus nop
  assign is_flag_op = (op.nib.lo == 4'h8 && op.nib.hi[0] && op.nib.hi != 4'h9) ||
                      (op.nib.hi == 4'hE && op.nib.lo == 4'hA);
  assign is_jmp     = op.nib.hi == 4'h4 && op.nib.lo == 4'hC;
  assign is_implied = is_trans || is_incdec || is_shift;

  assign grp_sel = grp_a ? `CPU_SEL_A : (op.f.group == 2'b10 ? `CPU_SEL_X : `CPU_SEL_Y);
  // x for the E8/CA/xA opcodes, y for the rest
  assign xy_sel  = (op.nib.lo == 4'hA || op.nib.hi == 4'hE) ? `CPU_SEL_X : `CPU_SEL_Y;

  always_comb begin
    src_sel = grp_sel;
    dst_sel = grp_sel;
    if (is_shift) begin
      src_sel = `CPU_SEL_A;
      dst_sel = `CPU_SEL_A;
    end else if (is_trans) begin
      // hi nibble A copies from a, otherwise into a
      src_sel = (op.nib.hi == 4'hA) ? `CPU_SEL_A : xy_sel;
      dst_sel = (op.nib.hi == 4'hA) ? xy_sel : `CPU_SEL_A;
    end else if (is_incdec) begin
      src_sel = xy_sel;
      dst_sel = xy_sel;
    end
  end

  always_comb begin
    case (op.f.opcode)
      3'b000:  alu_op = `CPU_ALU_OR;
      3'b001:  alu_op = `CPU_ALU_AND;
      3'b010:  alu_op = `CPU_ALU_EOR;
      3'b011:  alu_op = `CPU_ALU_ADD;
      default: alu_op = `CPU_ALU_SUB;
    endcase
    if (is_shift) begin
      alu_op = op.f.opcode[1] ? `CPU_ALU_SHR : `CPU_ALU_SHL;
    end else if (is_incdec) begin
      alu_op = is_inc ? `CPU_ALU_ADD : `CPU_ALU_SUB;
    end else if (!is_alu) begin
      // loads and transfers pass operand a through
      alu_op = `CPU_ALU_OR;
    end
  end

  always_comb begin
    assert #0 ($isunknown(op) ||
               $onehot0({is_load, is_store, is_alu, is_implied, is_flag_op, is_jmp}));
  end

endmodule

// File: hw/alu8.sv
`include "cpu_settings.svh"

module alu8 (
  input  logic [`CPU_DATA_W-1:0]   a,
  input  logic [`CPU_DATA_W-1:0]   b,
  input  logic                     cin,
  input  logic [`CPU_ALU_OP_W-1:0] sel,
  output logic [`CPU_DATA_W-1:0]   f,
  output logic                     cout,
  output logic                     v
);

  logic [`CPU_DATA_W-1:0] b_eff;
  logic [`CPU_DATA_W:0]   sum;

  // subtract is a + ~b + cin on the same adder
  assign b_eff = (sel == `CPU_ALU_SUB) ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{`CPU_DATA_W{1'b0}}, cin};

  always_comb begin
    f    = sum[`CPU_DATA_W-1:0];
    cout = cin;
    v    = 1'b0;
    case (sel)
      `CPU_ALU_OR:  f = a | b;
      `CPU_ALU_AND: f = a & b;
      `CPU_ALU_EOR: f = a ^ b;
      `CPU_ALU_ADD,
      `CPU_ALU_SUB: begin
        cout = sum[`CPU_DATA_W];
        // signed overflow when both inputs agree and the sign flips
        v = (a[`CPU_DATA_W-1] == b_eff[`CPU_DATA_W-1]) &&
            (sum[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
      end
      `CPU_ALU_SHL: begin
        f    = {a[`CPU_DATA_W-2:0], cin};
        cout = a[`CPU_DATA_W-1];
      end
      `CPU_ALU_SHR: begin
        f    = {cin, a[`CPU_DATA_W-1:1]};
        cout = a[0];
      end
      default: ;
    endcase
  end

endmodule

// File: hw/cpu_sequencer.sv
`include "cpu_settings.svh"

module cpu_sequencer import cpu_pkg::*; (
  input  logic                   CLK,
  input  logic                   R,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  input  logic                   is_load,
  input  logic                   is_store,
  input  logic                   is_alu,
  input  logic                   is_implied,
  input  logic                   is_flag_op,
  input  logic                   is_jmp,
  input  logic                   amode_imm,
  input  logic                   amode_zp,
  input  logic                   amode_abs,
  output logic [`CPU_ST_W-1:0]   curr_st,
  output op_word_t               op,
  output logic                   sync
);

  logic [`CPU_ST_W-1:0] st_next;
  op_word_t             op_q;
  logic                 uses_mem;

  // opcode arrives on the read bus during new_op
  assign op       = (curr_st == `CPU_ST_NEW_OP) ? op_word_t'(mem_rdata) : op_q;
  assign sync     = curr_st == `CPU_ST_NEW_OP;
  assign uses_mem = is_load || is_alu || is_store;

  always_comb begin
    case (curr_st)
      `CPU_ST_INITIAL: st_next = `CPU_ST_NEW_OP;
      `CPU_ST_NEW_OP: begin
        if (is_flag_op)
          st_next = `CPU_ST_NEW_OP;
        else if (is_implied || ((is_load || is_alu) && amode_imm))
          st_next = `CPU_ST_LOAD_REG;
        else if ((uses_mem && (amode_zp || amode_abs)) || is_jmp)
          st_next = `CPU_ST_LO_BYTE;
        else
          st_next = `CPU_ST_NEW_OP;
      end
      `CPU_ST_LO_BYTE: begin
        if (amode_zp)
          st_next = is_store ? `CPU_ST_WRITE_DATA : `CPU_ST_LOAD_REG;
        else
          st_next = `CPU_ST_HI_BYTE;
      end
      `CPU_ST_HI_BYTE: begin
        if (is_jmp)
          st_next = `CPU_ST_NEW_OP;
        else
          st_next = is_store ? `CPU_ST_WRITE_DATA : `CPU_ST_LOAD_REG;
      end
      `CPU_ST_WRITE_DATA: st_next = `CPU_ST_LOAD_REG;
      `CPU_ST_LOAD_REG:   st_next = `CPU_ST_NEW_OP;
      default:            st_next = `CPU_ST_INITIAL;
    endcase
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      curr_st <= `CPU_ST_INITIAL;
      op_q    <= '0;
    end else begin
      curr_st <= st_next;
      if (curr_st == `CPU_ST_NEW_OP)
        op_q <= op_word_t'(mem_rdata);
    end
  end

  assert property (@(posedge CLK) disable iff (R) $onehot0(curr_st));
  assert property (@(posedge CLK) disable iff (R)
    curr_st == `CPU_ST_INITIAL |=> curr_st == `CPU_ST_NEW_OP);

endmodule

// File: hw/cpu_datapath.sv
`include "cpu_settings.svh"

module cpu_datapath import cpu_pkg::*; (
  input  logic                     CLK,
  input  logic                     R,
  input  logic [`CPU_ST_W-1:0]     curr_st,
  input  op_word_t                 op,
  input  logic [`CPU_DATA_W-1:0]   mem_rdata,
  input  logic                     is_load,
  input  logic                     is_store,
  input  logic                     is_alu,
  input  logic                     is_implied,
  input  logic                     is_jmp,
  input  logic                     is_cmp,
  input  logic                     is_shift,
  input  logic                     is_incdec,
  input  logic                     amode_zp,
  input  logic                     amode_abs,
  input  logic [`CPU_ALU_OP_W-1:0] alu_op,
  input  logic [`CPU_SEL_W-1:0]    dst_sel,
  input  logic [`CPU_SEL_W-1:0]    src_sel,
  input  logic                     p_c,
  input  logic [`CPU_DATA_W-1:0]   alu_f,
  output logic [`CPU_ADDR_W-1:0]   mem_addr,
  output logic [`CPU_DATA_W-1:0]   mem_wdata,
  output logic                     mem_we,
  output logic [`CPU_DATA_W-1:0]   alu_a,
  output logic [`CPU_DATA_W-1:0]   alu_b,
  output logic                     alu_cin,
  output logic [`CPU_ALU_OP_W-1:0] alu_sel,
  output logic [`CPU_ADDR_W-1:0]   pc,
  output logic [`CPU_DATA_W-1:0]   reg_a,
  output logic [`CPU_DATA_W-1:0]   reg_x,
  output logic [`CPU_DATA_W-1:0]   reg_y
);

  logic [`CPU_ADDR_W-1:0] prev_addr;
  logic [`CPU_DATA_W-1:0] reg_l;
  logic [`CPU_DATA_W-1:0] src_val;
  logic                   pc_step;
  logic                   reg_wr;

  always_comb begin
    case (src_sel)
      `CPU_SEL_X: src_val = reg_x;
      `CPU_SEL_Y: src_val = reg_y;
      default:    src_val = reg_a;
    endcase
  end

  // zero page from the read byte, absolute from read byte and low latch
  always_comb begin
    case (curr_st)
      `CPU_ST_LO_BYTE:
        mem_addr = amode_zp ? {{(`CPU_ADDR_W-`CPU_DATA_W){1'b0}}, mem_rdata} : pc;
      `CPU_ST_HI_BYTE:    mem_addr = {mem_rdata, reg_l};
      `CPU_ST_WRITE_DATA: mem_addr = prev_addr;
      default:            mem_addr = pc;
    endcase
  end

  assign mem_we    = curr_st == `CPU_ST_WRITE_DATA && is_store;
  assign mem_wdata = src_val;

  // pc follows the bus whenever it steps, so jmp loads the target here
  assign pc_step = curr_st == `CPU_ST_INITIAL ||
                   (curr_st == `CPU_ST_NEW_OP && !is_implied) ||
                   (curr_st == `CPU_ST_LO_BYTE && amode_abs) ||
                   (curr_st == `CPU_ST_HI_BYTE && is_jmp) ||
                   curr_st == `CPU_ST_LOAD_REG;
  assign reg_wr  = curr_st == `CPU_ST_LOAD_REG && (is_load || is_implied || (is_alu && !is_cmp));

  assign alu_a   = is_load ? mem_rdata : src_val;
  assign alu_b   = is_alu ? mem_rdata : '0;
  assign alu_sel = alu_op;

  always_comb begin
    if (is_incdec)
      alu_cin = alu_op == `CPU_ALU_ADD;
    else if (is_cmp)
      alu_cin = 1'b1;
    else if (is_shift)
      // rol and ror carry in, asl and lsr shift in zero
      alu_cin = op.f.opcode[0] & p_c;
    else
      alu_cin = p_c;
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      pc    <= `CPU_RESET_PC;
      reg_a <= `CPU_RESET_REG;
      reg_x <= `CPU_RESET_REG;
      reg_y <= `CPU_RESET_REG;
    end else begin
      if (pc_step)
        pc <= mem_addr + 1'b1;
      if (reg_wr) begin
        case (dst_sel)
          `CPU_SEL_X: reg_x <= alu_f;
          `CPU_SEL_Y: reg_y <= alu_f;
          default:    reg_a <= alu_f;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    prev_addr <= mem_addr;
    reg_l     <= mem_rdata;
  end

  // only stores reach write_data, so the strobe marks exactly that state
  assert property (@(posedge CLK) disable iff (R)
    mem_we == (curr_st == `CPU_ST_WRITE_DATA));

endmodule

// File: hw/status_flags.sv
`include "cpu_settings.svh"

module status_flags import cpu_pkg::*; (
  input  logic                     CLK,
  input  logic                     R,
  input  logic [`CPU_ST_W-1:0]     curr_st,
  input  op_word_t                 op,
  input  logic                     is_load,
  input  logic                     is_alu,
  input  logic                     is_implied,
  input  logic                     is_flag_op,
  input  logic                     is_cmp,
  input  logic                     is_shift,
  input  logic [`CPU_ALU_OP_W-1:0] alu_op,
  input  logic [`CPU_DATA_W-1:0]   mem_rdata,
  input  logic [`CPU_DATA_W-1:0]   alu_f,
  input  logic                     alu_cout,
  input  logic                     alu_v,
  output logic [`CPU_DATA_W-1:0]   reg_p
);

  logic [`CPU_DATA_W-1:0] res;
  logic                   arith;

  assign res   = is_load ? mem_rdata : alu_f;
  assign arith = is_alu && (alu_op == `CPU_ALU_ADD || alu_op == `CPU_ALU_SUB);

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      reg_p <= `CPU_RESET_P;
    end else if (curr_st == `CPU_ST_NEW_OP && is_flag_op && op.nib.lo == 4'h8) begin
      // hi nibble bits 3:2 pick the flag, bit 1 is the new value
      case (op.nib.hi[3:2])
        2'b00: reg_p[`CPU_P_C] <= op.nib.hi[1];
        2'b01: reg_p[`CPU_P_I] <= op.nib.hi[1];
        2'b10: reg_p[`CPU_P_V] <= 1'b0;
        2'b11: reg_p[`CPU_P_D] <= op.nib.hi[1];
      endcase
    end else if (curr_st == `CPU_ST_LOAD_REG) begin
      if (is_load || is_implied || is_alu) begin
        reg_p[`CPU_P_N] <= res[`CPU_DATA_W-1];
        reg_p[`CPU_P_Z] <= res == '0;
      end
      if (arith || is_shift)
        reg_p[`CPU_P_C] <= alu_cout;
      // cmp leaves v alone
      if (arith && !is_cmp)
        reg_p[`CPU_P_V] <= alu_v;
    end
  end

endmodule

// File: hw/cpu_core.sv
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
  input  logic                   CLK,
  input  logic                   R,
  output logic [`CPU_ADDR_W-1:0] mem_addr,
  output logic [`CPU_DATA_W-1:0] mem_wdata,
  output logic                   mem_we,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  output logic                   sync,
  output logic [`CPU_ADDR_W-1:0] pc,
  output logic [`CPU_DATA_W-1:0] reg_a,
  output logic [`CPU_DATA_W-1:0] reg_x,
  output logic [`CPU_DATA_W-1:0] reg_y,
  output logic [`CPU_DATA_W-1:0] reg_p
);

  logic [`CPU_ST_W-1:0]     curr_st;
  op_word_t                 op;
  logic                     is_load;
  logic                     is_store;
  logic                     is_alu;
  logic                     is_implied;
  logic                     is_flag_op;
  logic                     is_jmp;
  logic                     amode_imm;
  logic                     amode_zp;
  logic                     amode_abs;
  logic                     is_cmp;
  logic                     is_shift;
  logic                     is_incdec;
  logic [`CPU_ALU_OP_W-1:0] alu_op;
  logic [`CPU_ALU_OP_W-1:0] alu_sel;
  logic [`CPU_SEL_W-1:0]    dst_sel;
  logic [`CPU_SEL_W-1:0]    src_sel;
  logic [`CPU_DATA_W-1:0]   alu_a;
  logic [`CPU_DATA_W-1:0]   alu_b;
  logic [`CPU_DATA_W-1:0]   alu_f;
  logic                     alu_cin;
  logic                     alu_cout;
  logic                     alu_v;

  cpu_sequencer u_seq (
    .CLK(CLK), .R(R), .mem_rdata(mem_rdata),
    .is_load(is_load), .is_store(is_store), .is_alu(is_alu),
    .is_implied(is_implied), .is_flag_op(is_flag_op), .is_jmp(is_jmp),
    .amode_imm(amode_imm), .amode_zp(amode_zp), .amode_abs(amode_abs),
    .curr_st(curr_st), .op(op), .sync(sync)
  );

  instr_decoder u_dec (
    .op(op), .is_load(is_load), .is_store(is_store), .is_alu(is_alu),
    .is_implied(is_implied), .is_flag_op(is_flag_op), .is_jmp(is_jmp),
    .amode_imm(amode_imm), .amode_zp(amode_zp), .amode_abs(amode_abs),
    .is_cmp(is_cmp), .is_shift(is_shift), .is_incdec(is_incdec),
    .alu_op(alu_op), .dst_sel(dst_sel), .src_sel(src_sel)
  );

  cpu_datapath u_dp (
    .CLK(CLK), .R(R), .curr_st(curr_st), .op(op), .mem_rdata(mem_rdata),
    .is_load(is_load), .is_store(is_store), .is_alu(is_alu),
    .is_implied(is_implied), .is_jmp(is_jmp), .is_cmp(is_cmp),
    .is_shift(is_shift), .is_incdec(is_incdec),
    .amode_zp(amode_zp), .amode_abs(amode_abs), .alu_op(alu_op),
    .dst_sel(dst_sel), .src_sel(src_sel), .p_c(reg_p[`CPU_P_C]), .alu_f(alu_f),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
    .alu_a(alu_a), .alu_b(alu_b), .alu_cin(alu_cin), .alu_sel(alu_sel),
    .pc(pc), .reg_a(reg_a), .reg_x(reg_x), .reg_y(reg_y)
  );

  alu8 u_alu (
    .a(alu_a), .b(alu_b), .cin(alu_cin), .sel(alu_sel),
    .f(alu_f), .cout(alu_cout), .v(alu_v)
  );

  status_flags u_flags (
    .CLK(CLK), .R(R), .curr_st(curr_st), .op(op),
    .is_load(is_load), .is_alu(is_alu), .is_implied(is_implied),
    .is_flag_op(is_flag_op), .is_cmp(is_cmp), .is_shift(is_shift),
    .alu_op(alu_op), .mem_rdata(mem_rdata), .alu_f(alu_f),
    .alu_cout(alu_cout), .alu_v(alu_v), .reg_p(reg_p)
  );

endmodule

// File: testbench/tb_cpu_core.sv
`include "cpu_settings.svh"

module tb_cpu_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 4;
  // reset, initial cycle and program for each run, long enough for the worst case
  localparam int RUN_CYCLES = 9 * 15 + 6 * 18 + 18 * 18 + 63 + 16;

  logic                   CLK;
  logic                   R;
  logic [`CPU_ADDR_W-1:0] mem_addr;
  logic [`CPU_DATA_W-1:0] mem_wdata;
  logic                   mem_we;
  logic [`CPU_DATA_W-1:0] mem_rdata;
  logic                   sync;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_DATA_W-1:0] reg_a;
  logic [`CPU_DATA_W-1:0] reg_x;
  logic [`CPU_DATA_W-1:0] reg_y;
  logic [`CPU_DATA_W-1:0] reg_p;

  logic [`CPU_DATA_W-1:0] mem [0:65535];
  logic [`CPU_DATA_W-1:0] rd_byte;
  logic [`CPU_ADDR_W-1:0] wp;
  logic [`CPU_ADDR_W-1:0] wr_addr;
  logic [`CPU_DATA_W-1:0] wr_data;
  int                     wr_cnt;
  int                     seed;
  int                     n_checks;
  int                     n_val_err;
  int                     n_other_err;
  logic [`CPU_DATA_W-1:0] exp_a;
  logic [`CPU_DATA_W-1:0] exp_x;
  logic [`CPU_DATA_W-1:0] exp_y;
  logic [`CPU_DATA_W-1:0] exp_p;

  // transfers, inc/dec with wrap, shifts, then every flag op and nop
  logic [7:0] implied_seq [22] = '{8'hE8, 8'hCA, 8'h88, 8'hC8, 8'hAA, 8'h38, 8'h2A, 8'h6A,
                                   8'h0A, 8'h4A, 8'h18, 8'h2A, 8'h6A, 8'h8A, 8'hA8, 8'h98,
                                   8'h78, 8'h58, 8'hF8, 8'hD8, 8'hB8, 8'hEA};

  cpu_core i_dut (
    .CLK(CLK), .R(R), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
    .mem_rdata(mem_rdata), .sync(sync), .pc(pc), .reg_a(reg_a), .reg_x(reg_x),
    .reg_y(reg_y), .reg_p(reg_p)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // byte memory, read data shows up one cycle after the address
  always @(posedge CLK) begin
    if (mem_we) begin
      mem[mem_addr] = mem_wdata;
      wr_addr = mem_addr;
      wr_data = mem_wdata;
      wr_cnt++;
    end
    rd_byte = mem[mem_addr];
    #1 mem_rdata = rd_byte;
  end

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // opcode from the mode 0 base, where group 01 keeps immediate at +8
  function automatic logic [7:0] mode_op(input logic [7:0] base, input int m);
    case (m)
      1: return base + 8'h04;
      2: return base + 8'h0C;
      default: return base + (base[0] ? 8'h08 : 8'h00);
    endcase
  endfunction

  function automatic logic [7:0] reg_group(input int r);
    case (r)
      0: return 8'h01;
      1: return 8'h02;
      default: return 8'h00;
    endcase
  endfunction

  task automatic check_byte(input string name, input logic [`CPU_DATA_W-1:0] got,
                            input logic [`CPU_DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_val_err++;
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input logic [`CPU_ADDR_W-1:0] got,
                            input logic [`CPU_ADDR_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_val_err++;
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_regs();
    if (sync !== 1'b1) begin
      n_other_err++;
      $display("core is not at an opcode fetch when results are due at %0t", $time);
    end
    check_byte("reg_a", reg_a, exp_a);
    check_byte("reg_x", reg_x, exp_x);
    check_byte("reg_y", reg_y, exp_y);
    check_byte("reg_p", reg_p, exp_p);
  endtask

  task automatic set_nz(input logic [7:0] v);
    exp_p[`CPU_P_N] = v[7];
    exp_p[`CPU_P_Z] = v == 8'h00;
  endtask

  task automatic reset_model();
    exp_a = 8'h00;
    exp_x = 8'h00;
    exp_y = 8'h00;
    exp_p = 8'h00;
  endtask

  task automatic set_reg(input int r, input logic [7:0] v);
    case (r)
      0: exp_a = v;
      1: exp_x = v;
      default: exp_y = v;
    endcase
    set_nz(v);
  endtask

  // ora, and, eor, adc, sbc, cmp on the expected accumulator
  task automatic alu_expect(input int k, input logic [7:0] m);
    logic [8:0] t;
    case (k)
      0: exp_a = exp_a | m;
      1: exp_a = exp_a & m;
      2: exp_a = exp_a ^ m;
      3: begin
        t = exp_a + m + exp_p[`CPU_P_C];
        exp_p[`CPU_P_V] = (exp_a[7] == m[7]) && (t[7] != exp_a[7]);
        exp_p[`CPU_P_C] = t[8];
        exp_a = t[7:0];
      end
      4: begin
        t = {1'b0, exp_a} - m - !exp_p[`CPU_P_C];
        exp_p[`CPU_P_V] = (exp_a[7] != m[7]) && (t[7] != exp_a[7]);
        exp_p[`CPU_P_C] = !t[8];
        exp_a = t[7:0];
      end
      default: begin
        t = {1'b0, exp_a} - m;
        exp_p[`CPU_P_C] = exp_a >= m;
      end
    endcase
    set_nz((k == 5) ? t[7:0] : exp_a);
  endtask

  task automatic implied_expect(input logic [7:0] opc, output int cyc);
    logic c;
    c = exp_p[`CPU_P_C];
    cyc = 2;
    case (opc)
      8'hAA: exp_x = exp_a;
      8'h8A: exp_a = exp_x;
      8'hA8: exp_y = exp_a;
      8'h98: exp_a = exp_y;
      8'hE8: exp_x = exp_x + 8'h01;
      8'hC8: exp_y = exp_y + 8'h01;
      8'hCA: exp_x = exp_x - 8'h01;
      8'h88: exp_y = exp_y - 8'h01;
      8'h0A: {exp_p[`CPU_P_C], exp_a} = {exp_a, 1'b0};
      8'h2A: {exp_p[`CPU_P_C], exp_a} = {exp_a, c};
      8'h4A: {exp_a, exp_p[`CPU_P_C]} = {1'b0, exp_a};
      8'h6A: {exp_a, exp_p[`CPU_P_C]} = {c, exp_a};
      default: cyc = 1;
    endcase
    case (opc)
      8'hAA, 8'hE8, 8'hCA: set_nz(exp_x);
      8'hA8, 8'hC8, 8'h88: set_nz(exp_y);
      8'h8A, 8'h98, 8'h0A, 8'h2A, 8'h4A, 8'h6A: set_nz(exp_a);
      8'h18: exp_p[`CPU_P_C] = 1'b0;
      8'h38: exp_p[`CPU_P_C] = 1'b1;
      8'h58: exp_p[`CPU_P_I] = 1'b0;
      8'h78: exp_p[`CPU_P_I] = 1'b1;
      8'hB8: exp_p[`CPU_P_V] = 1'b0;
      8'hD8: exp_p[`CPU_P_D] = 1'b0;
      8'hF8: exp_p[`CPU_P_D] = 1'b1;
      default: ;
    endcase
  endtask

  task automatic new_prog();
    for (int i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ i[7:0] ^ 8'h5C;
    wp = `CPU_RESET_PC;
    wr_cnt = 0;
  endtask

  task automatic emit(input logic [7:0] b);
    mem[wp] = b;
    wp = wp + 16'h0001;
  endtask

  // nops after the program keep the fetch beyond the last check harmless
  task automatic pad();
    emit(8'hEA);
    emit(8'hEA);
  endtask

  task automatic emit_addr(input logic [7:0] opc, input int m, output logic [15:0] a);
    a = (m == 1) ? {8'h00, rand_byte()} : {8'h30 | (rand_byte() & 8'h0F), rand_byte()};
    emit(opc);
    emit(a[7:0]);
    if (m == 2)
      emit(a[15:8]);
  endtask

  task automatic put_operand(input logic [7:0] opc, input int m, input logic [7:0] v);
    logic [15:0] a;
    if (m == 0) begin
      emit(opc);
      emit(v);
    end else begin
      emit_addr(opc, m, a);
      mem[a] = v;
    end
  endtask

  // reset, one initial cycle, then n program cycles
  task automatic run(input int n);
    @(posedge CLK);
    #1 R = 1'b1;
    repeat (8) @(posedge CLK);
    #1 R = 1'b0;
    repeat (n + 1) @(posedge CLK);
    @(negedge CLK);
  endtask

  task automatic step(input int n);
    repeat (n) @(posedge CLK);
    @(negedge CLK);
  endtask

  task automatic test_loads();
    logic [7:0] v;
    for (int r = 0; r < 3; r++) begin
      for (int m = 0; m < 3; m++) begin
        v = rand_byte();
        new_prog();
        put_operand(mode_op(8'hA0 | reg_group(r), m), m, v);
        pad();
        run(2 + m);
        reset_model();
        set_reg(r, v);
        check_regs();
      end
    end
  endtask

  task automatic test_stores();
    logic [7:0]  v;
    logic [15:0] a;
    for (int r = 0; r < 3; r++) begin
      for (int m = 1; m < 3; m++) begin
        v = rand_byte();
        new_prog();
        put_operand(mode_op(8'hA0 | reg_group(r), 0), 0, v);
        emit_addr(mode_op(8'h80 | reg_group(r), m), m, a);
        pad();
        run(5 + m);
        reset_model();
        set_reg(r, v);
        check_regs();
        if (wr_cnt != 1) begin
          n_other_err++;
          $display("store produced %0d write strobes instead of one at %0t", wr_cnt, $time);
        end
        check_addr("mem_addr", wr_addr, a);
        check_byte("mem_wdata", wr_data, v);
        check_byte("mem", mem[a], v);
      end
    end
  endtask

  task automatic test_alu();
    logic [7:0] va;
    logic [7:0] vm;
    logic [7:0] opc;
    logic       c;
    for (int k = 0; k < 6; k++) begin
      for (int m = 0; m < 3; m++) begin
        va = rand_byte();
        vm = rand_byte();
        c = rand_byte() > 8'h7F;
        // sbc and cmp sit at opcode fields 111 and 110
        opc = {(k == 4) ? 3'd7 : (k == 5) ? 3'd6 : k[2:0], 5'b00001};
        new_prog();
        emit(c ? 8'h38 : 8'h18);
        put_operand(8'hA9, 0, va);
        put_operand(mode_op(opc, m), m, vm);
        pad();
        run(5 + m);
        reset_model();
        exp_p[`CPU_P_C] = c;
        set_reg(0, va);
        alu_expect(k, vm);
        check_regs();
      end
    end
  endtask

  task automatic test_implied();
    logic [7:0] va;
    int         cyc;
    va = rand_byte();
    new_prog();
    // 7f plus 1 leaves v set for clv
    put_operand(8'hA9, 0, 8'h7F);
    put_operand(8'h69, 0, 8'h01);
    put_operand(8'hA9, 0, va);
    put_operand(8'hA2, 0, 8'hFF);
    put_operand(8'hA0, 0, 8'h00);
    foreach (implied_seq[i])
      emit(implied_seq[i]);
    pad();
    run(10);
    reset_model();
    exp_a = 8'h7F;
    alu_expect(3, 8'h01);
    exp_a = va;
    exp_x = 8'hFF;
    set_reg(2, 8'h00);
    check_regs();
    foreach (implied_seq[i]) begin
      implied_expect(implied_seq[i], cyc);
      step(cyc);
      check_regs();
    end
  endtask

  task automatic test_jmp();
    logic [15:0] t;
    logic [7:0]  v;
    t = {8'h10 + (rand_byte() & 8'h7F), rand_byte()};
    v = rand_byte();
    new_prog();
    emit(8'h4C);
    emit(t[7:0]);
    emit(t[15:8]);
    wp = t;
    put_operand(8'hA9, 0, v);
    pad();
    run(2);
    // hi byte cycle fetches the opcode at the target
    check_addr("mem_addr", mem_addr, t);
    if (sync !== 1'b0) begin
      n_other_err++;
      $display("sync is high before the jump completes at %0t", $time);
    end
    step(1);
    if (sync !== 1'b1) begin
      n_other_err++;
      $display("sync stays low after the jump at %0t", $time);
    end
    check_addr("pc", pc, t + 16'h0001);
    step(2);
    reset_model();
    set_reg(0, v);
    check_regs();
  endtask

  initial begin
    #((RUN_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    CLK = 1'b0;
    R = 1'b1;
    mem_rdata = 8'h00;
    seed = 82;
    wr_cnt = 0;
    n_checks = 0;
    n_val_err = 0;
    n_other_err = 0;
    test_loads();
    test_stores();
    test_alu();
    test_implied();
    test_jmp();
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, n_val_err, n_other_err);
    if (n_val_err + n_other_err == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: cpu_core.f
+incdir+include
hw/cpu_pkg.sv
hw/instr_decoder.sv
hw/alu8.sv
hw/cpu_sequencer.sv
hw/cpu_datapath.sv
hw/status_flags.sv
hw/cpu_core.sv
testbench/tb_cpu_core.sv
